// File: source/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;

    // Subset opcodes with NOT on 4'b1001
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    // Operate view for ADD, AND and NOT
    // In register form sr2 is imm5[2:0]
    typedef struct packed {
        lc3b_opcode      opcode;
        lc3b_reg         dr;
        lc3b_reg         sr1;
        logic            imm;
        logic [4:0]      imm5;
    } lc3b_operate_t;

    // LDR and STR use base plus offset6, BR and LEA use offset9
    typedef union packed {
        struct packed {
            lc3b_reg     base;
            logic [5:0]  offset6;
        } mem;
        logic [8:0]      offset9;
    } lc3b_offset_field_t;

    // dr doubles as the nzp mask for BR
    typedef struct packed {
        lc3b_opcode         opcode;
        lc3b_reg            dr;
        lc3b_offset_field_t off;
    } lc3b_offset_t;

    typedef union packed {
        lc3b_operate_t operate;
        lc3b_offset_t  offset;
    } lc3b_instr;

    localparam lc3b_word RESET_PC = 16'h0000;
    localparam logic [2:0] CC_Z = 3'b010;

endpackage

// File: source/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    import lc3b_isa_pkg::*;

    typedef enum logic [1:0] {
        alumux_reg_b   = 2'b00,
        alumux_imm5    = 2'b01,
        alumux_offset6 = 2'b10
    } lc3b_alumux_t;

    typedef enum logic [1:0] {
        regfilemux_alu        = 2'b00,
        regfilemux_mdr        = 2'b01,
        regfilemux_pc_offset9 = 2'b10
    } lc3b_regfilemux_t;

    typedef struct packed {
        logic             load_pc;
        logic             load_ir;
        logic             load_regfile;
        logic             load_mar;
        logic             load_mdr;
        logic             load_cc;
        logic             pcmux_sel;
        logic             storemux_sel;
        logic             marmux_sel;
        logic             mdrmux_sel;
        lc3b_alumux_t     alumux;
        lc3b_regfilemux_t regfilemux;
        lc3b_aluop        aluop;
    } lc3b_ctrl_t;

    localparam lc3b_ctrl_t CTRL_IDLE = '{
        load_pc: 1'b0, load_ir: 1'b0, load_regfile: 1'b0, load_mar: 1'b0,
        load_mdr: 1'b0, load_cc: 1'b0, pcmux_sel: 1'b0, storemux_sel: 1'b0,
        marmux_sel: 1'b0, mdrmux_sel: 1'b0, alumux: alumux_reg_b,
        regfilemux: regfilemux_alu, aluop: alu_add
    };

endpackage

// File: source/lc3b_regfile.sv
`timescale 1ns/1ns

module lc3b_regfile import lc3b_isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    input  lc3b_reg  dest,
    input  lc3b_word in,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // Reads are combinational, a write shows up next cycle
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule

// File: source/lc3b_control.sv
`timescale 1ns/1ns

module lc3b_control import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  lc3b_instr  instr,
    input  logic       branch_enable,
    input  logic       mem_resp,
    output lc3b_ctrl_t ctrl,
    output logic       mem_read,
    output logic       mem_write
);

    typedef enum logic [3:0] {
        fetch1, fetch2, fetch3, decode,
        s_add, s_and, s_not,
        br, br_taken,
        calc_addr, ldr1, ldr2, str1, str2,
        lea
    } state_t;

    state_t state;
    state_t next_state;
    lc3b_opcode opcode;

    assign opcode = instr.operate.opcode;

    always_comb begin
        ctrl = CTRL_IDLE;
        mem_read = 1'b0;
        mem_write = 1'b0;
        case (state)
            fetch1: begin
                // MAR from PC, PC advances by one word
                ctrl.marmux_sel = 1'b1;
                ctrl.load_mar = 1'b1;
                ctrl.load_pc = 1'b1;
            end
            fetch2: begin
                mem_read = 1'b1;
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr = mem_resp;
            end
            fetch3: ctrl.load_ir = 1'b1;
            s_add, s_and: begin
                // imm flag picks register or sign-extended imm5
                ctrl.alumux = instr.operate.imm ? alumux_imm5 : alumux_reg_b;
                ctrl.aluop = (state == s_add) ? alu_add : alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            s_not: begin
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            br_taken: begin
                ctrl.pcmux_sel = 1'b1;
                ctrl.load_pc = 1'b1;
            end
            calc_addr: begin
                // Effective address is base + sext(offset6) << 1
                ctrl.alumux = alumux_offset6;
                ctrl.aluop = alu_add;
                ctrl.load_mar = 1'b1;
            end
            ldr1: begin
                mem_read = 1'b1;
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr = mem_resp;
            end
            ldr2: begin
                ctrl.regfilemux = regfilemux_mdr;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            str1: begin
                // Store register passes through the ALU into MDR
                ctrl.storemux_sel = 1'b1;
                ctrl.aluop = alu_pass;
                ctrl.load_mdr = 1'b1;
            end
            str2: mem_write = 1'b1;
            lea: begin
                ctrl.regfilemux = regfilemux_pc_offset9;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            fetch1: next_state = fetch2;
            fetch2: if (mem_resp) next_state = fetch3;
            fetch3: next_state = decode;
            decode: begin
                case (opcode)
                    op_add: next_state = s_add;
                    op_and: next_state = s_and;
                    op_not: next_state = s_not;
                    op_br: next_state = br;
                    op_ldr, op_str: next_state = calc_addr;
                    op_lea: next_state = lea;
                    // Anything else behaves as a no-op
                    default: next_state = fetch1;
                endcase
            end
            br: next_state = branch_enable ? br_taken : fetch1;
            calc_addr: next_state = (opcode == op_ldr) ? ldr1 : str1;
            ldr1: if (mem_resp) next_state = ldr2;
            str1: next_state = str2;
            str2: if (mem_resp) next_state = fetch1;
            default: next_state = fetch1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fetch1;
        end else begin
            state <= next_state;
        end
    end

endmodule

// File: source/lc3b_datapath.sv
`timescale 1ns/1ns

module lc3b_datapath import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  lc3b_ctrl_t ctrl,
    input  lc3b_word   mem_rdata,
    output lc3b_instr  instr,
    output logic       branch_enable,
    output lc3b_word   mem_address,
    output lc3b_word   mem_wdata
);

    lc3b_word   pc;
    lc3b_instr  ir;
    lc3b_word   mar;
    lc3b_word   mdr;
    logic [2:0] cc;

    lc3b_reg  src_a;
    lc3b_word reg_a;
    lc3b_word reg_b;
    lc3b_word alu_b;
    lc3b_word alu_out;
    lc3b_word regfile_in;
    lc3b_word pc_plus2;
    lc3b_word pc_offset9;
    lc3b_word sext_imm5;
    lc3b_word sext_offset6;
    lc3b_word sext_offset9;

    // Offsets are word counts, hence the shift by one
    assign sext_imm5 = {{11{ir.operate.imm5[4]}}, ir.operate.imm5};
    assign sext_offset6 = {{9{ir.offset.off.mem.offset6[5]}}, ir.offset.off.mem.offset6, 1'b0};
    assign sext_offset9 = {{6{ir.offset.off.offset9[8]}}, ir.offset.off.offset9, 1'b0};

    // PC already points past the current instruction here
    assign pc_plus2 = pc + 16'd2;
    assign pc_offset9 = pc + sext_offset9;

    // STR reads its source from the dr field
    assign src_a = ctrl.storemux_sel ? ir.offset.dr : ir.operate.sr1;

    always_comb begin
        case (ctrl.alumux)
            alumux_imm5: alu_b = sext_imm5;
            alumux_offset6: alu_b = sext_offset6;
            default: alu_b = reg_b;
        endcase
    end

    always_comb begin
        case (ctrl.aluop)
            alu_add: alu_out = reg_a + alu_b;
            alu_and: alu_out = reg_a & alu_b;
            alu_not: alu_out = ~reg_a;
            default: alu_out = reg_a;
        endcase
    end

    always_comb begin
        case (ctrl.regfilemux)
            regfilemux_mdr: regfile_in = mdr;
            regfilemux_pc_offset9: regfile_in = pc_offset9;
            default: regfile_in = alu_out;
        endcase
    end

    lc3b_regfile i_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (ctrl.load_regfile),
        .src_a (src_a),
        .src_b (ir.operate.imm5[2:0]),
        .dest  (ir.operate.dr),
        .in    (regfile_in),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
            cc <= CC_Z;
        end else begin
            if (ctrl.load_pc) pc <= ctrl.pcmux_sel ? pc_offset9 : pc_plus2;
            // n, z, p from the value written back
            if (ctrl.load_cc) cc <= {regfile_in[15], regfile_in == '0,
                                     !regfile_in[15] && regfile_in != '0};
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir) ir <= mdr;
        if (ctrl.load_mar) mar <= ctrl.marmux_sel ? pc : alu_out;
        if (ctrl.load_mdr) mdr <= ctrl.mdrmux_sel ? mem_rdata : alu_out;
    end

    assign branch_enable = |(cc & ir.offset.dr);
    assign instr = ir;
    assign mem_address = mar;
    assign mem_wdata = mdr;

endmodule

// File: source/lc3b_cpu.sv
`timescale 1ns/1ns

module lc3b_cpu import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  lc3b_word mem_rdata,
    input  logic     mem_resp,
    output logic     mem_read,
    output logic     mem_write,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata
);

    lc3b_ctrl_t ctrl;
    lc3b_instr  instr;
    logic       branch_enable;

    lc3b_control i_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (instr),
        .branch_enable (branch_enable),
        .mem_resp      (mem_resp),
        .ctrl          (ctrl),
        .mem_read      (mem_read),
        .mem_write     (mem_write)
    );

    lc3b_datapath i_datapath (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (ctrl),
        .mem_rdata     (mem_rdata),
        .instr         (instr),
        .branch_enable (branch_enable),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata)
    );

endmodule

// File: tests/lc3b_cpu_asserts.sv
`timescale 1ns/1ns

module lc3b_cpu_asserts import lc3b_ctrl_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       mem_read,
    input logic       mem_write,
    input logic       mem_resp,
    input lc3b_ctrl_t ctrl
);

    int failures = 0;

    // One access at a time on the port
    no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write are high together");
            failures++;
        end

    read_holds: assert property (@(posedge clk) disable iff (!rst_n)
        mem_read && !mem_resp |=> mem_read)
        else begin
            $error("mem_read dropped before mem_resp");
            failures++;
        end

    write_holds: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write && !mem_resp |=> mem_write)
        else begin
            $error("mem_write dropped before mem_resp");
            failures++;
        end

    // MAR must not move under a waiting access
    mar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) |-> !ctrl.load_mar)
        else begin
            $error("MAR loaded while an access is pending");
            failures++;
        end

    strobes_in_reset: assert property (@(posedge clk)
        !rst_n |=> !mem_read && !mem_write)
        else begin
            $error("memory strobe active after a reset edge");
            failures++;
        end

endmodule

bind lc3b_control lc3b_cpu_asserts i_cpu_asserts (.*);

// File: tests/lc3b_cpu_tb.sv
`timescale 1ns/1ns

module lc3b_cpu_tb import lc3b_isa_pkg::*; ();

    localparam int MEM_WORDS = 256;
    localparam int RESET_CYCLES = 16;
    localparam string CASES_FILE = "tests/lc3b_cpu_cases.txt";

    typedef struct packed {
        lc3b_word addr;
        lc3b_word data;
    } store_t;

    logic     clk = 1'b0;
    logic     rst_n;
    lc3b_word mem_rdata = '0;
    logic     mem_resp = 1'b0;
    logic     mem_read;
    logic     mem_write;
    lc3b_word mem_address;
    lc3b_word mem_wdata;

    lc3b_word    mem [MEM_WORDS];
    store_t      expected_q [$];
    int          errors = 0;
    int          stores_seen = 0;
    int          m_records = 0;
    int          cycles = 0;
    int          cycle_limit;
    logic [31:0] rng_state = 32'h14d8_155e;
    int          wait_left = 0;
    logic        busy = 1'b0;

    lc3b_cpu i_lc3b_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Unused words hold undefined opcodes tagged with their address
    task automatic load_cases();
        int       fd;
        int       n;
        string    line;
        byte      kind;
        lc3b_word addr;
        lc3b_word data;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {8'hd0, i[7:0]};
        end
        fd = $fopen(CASES_FILE, "r");
        assert (fd != 0) else begin
            $display("Cannot open the cases file %s", CASES_FILE);
            errors++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h", kind, addr, data);
                if (n == 3 && kind == "M") begin
                    mem[addr[8:1]] = data;
                    m_records++;
                end else if (n == 3 && kind == "W") begin
                    expected_q.push_back('{addr: addr, data: data});
                end
            end
            $fclose(fd);
        end
    endtask

    // Completes the pending access on the edge that raises mem_resp
    task automatic access_memory();
        store_t expected;
        assert (mem_address[15:9] == '0) else begin
            $display("Access to %h lies outside the memory model", mem_address);
            errors++;
        end
        if (mem_read) begin
            mem_rdata <= mem[mem_address[8:1]];
        end else begin
            stores_seen++;
            assert (expected_q.size() > 0) else begin
                $display("Unexpected store of %h to %h", mem_wdata, mem_address);
                errors++;
            end
            if (expected_q.size() > 0) begin
                expected = expected_q.pop_front();
                assert (mem_address == expected.addr) else begin
                    $display("Mismatch mem_address: got %h, expected %h",
                             mem_address, expected.addr);
                    errors++;
                end
                assert (mem_wdata == expected.data) else begin
                    $display("Mismatch mem_wdata: got %h, expected %h",
                             mem_wdata, expected.data);
                    errors++;
                end
            end
            mem[mem_address[8:1]] = mem_wdata;
        end
    endtask

    // Memory with 0 to 3 random wait cycles per access
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_resp <= 1'b0;
            busy = 1'b0;
        end else if (mem_resp) begin
            // DUT takes the response on this edge
            mem_resp <= 1'b0;
        end else if (mem_read || mem_write) begin
            if (!busy) begin
                rng_state = xorshift32(rng_state);
                wait_left = rng_state[1:0];
                busy = 1'b1;
            end
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                busy = 1'b0;
                mem_resp <= 1'b1;
                access_memory();
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        load_cases();
        assert (expected_q.size() > 0) else begin
            $display("No expected stores were read from %s", CASES_FILE);
            errors++;
        end
        cycle_limit = 40 * m_records + 200;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (expected_q.size() > 0 && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (expected_q.size() == 0) else begin
            $display("Timeout after %0d cycles with %0d stores still missing",
                     cycles, expected_q.size());
            errors++;
        end
        assert (i_lc3b_cpu.i_control.i_cpu_asserts.failures == 0) else begin
            $display("Bound protocol assertions failed %0d times",
                     i_lc3b_cpu.i_control.i_cpu_asserts.failures);
            errors++;
        end
        $display("Errors: %0d, stores seen: %0d, cycles: %0d", errors, stores_seen, cycles);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: Bender.yml
package:
  name: lc3b_cpu

sources:
  - source/lc3b_isa_pkg.sv
  - source/lc3b_ctrl_pkg.sv
  - source/lc3b_regfile.sv
  - source/lc3b_control.sv
  - source/lc3b_datapath.sv
  - source/lc3b_cpu.sv
  - target: test
    files:
      - tests/lc3b_cpu_asserts.sv
      - tests/lc3b_cpu_tb.sv

// File: lc3b_cpu.f
source/lc3b_isa_pkg.sv
source/lc3b_ctrl_pkg.sv
source/lc3b_regfile.sv
source/lc3b_control.sv
source/lc3b_datapath.sv
source/lc3b_cpu.sv
tests/lc3b_cpu_asserts.sv
tests/lc3b_cpu_tb.sv

// File: tests/lc3b_cpu_cases.txt
# M byte_address word: memory image, program from 0000 and data at 0100
# W byte_address word: expected stores in program order
M 0000 EE7F
M 0002 63C0
M 0004 69C1
M 0006 79D0
M 0008 0601
M 000A 0801
M 000C 73DF
M 000E 1644
M 0010 77D1
M 0012 167D
M 0014 77D2
M 0016 0C01
M 0018 0201
M 001A 73DF
M 001C 5644
M 001E 77D3
M 0020 5670
M 0022 77D4
M 0024 5A60
M 0026 0A01
M 0028 0401
M 002A 73DF
M 002C 967F
M 002E 77D5
M 0030 DA5A
M 0032 EBFF
M 0034 7BFC
M 0036 0FFF
M 0100 1234
M 0102 BEEF
W 0120 BEEF
W 0122 D123
W 0124 1231
W 0126 1224
W 0128 1230
W 012A EDCB
W 00F8 0032
